//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := tb_ex_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- count_bit_word.sv
`timescale 1ns/100ps

module count_bit_word (
    input  ex_pkg::word_t data_i,
    input  logic          bit_i,
    output ex_pkg::word_t cnt_o
);

    logic run;

    // Walk down from the MSB until the first mismatch.
    always_comb begin
        cnt_o = '0;
        run   = 1'b1;
        for (int i = 31; i >= 0; i--) begin
            if (run && (data_i[i] == bit_i)) begin
                cnt_o = cnt_o + 32'd1;
            end else begin
                run = 1'b0;
            end
        end
    end

endmodule

//--- ex.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex (
    input  ex_pkg::alu_op_t    op_i,
    input  ex_pkg::op_type_t   op_type_i,
    input  ex_pkg::word_t      address_i,
    input  ex_pkg::reg_idx_t   reg_s_i,
    input  ex_pkg::reg_idx_t   reg_t_i,
    input  ex_pkg::reg_idx_t   reg_d_i,
    input  ex_pkg::word_t      reg_s_value_i,
    input  ex_pkg::word_t      reg_t_value_i,
    input  logic [15:0]        immediate_i,
    input  logic               flag_unsigned_i,
    input  ex_pkg::dword_t     hilo_value_i,
    input  ex_pkg::word_t      cp0_rd_data_i,
    input  ex_pkg::dword_t     mul_result_i,
    input  logic               mul_done_i,
    input  ex_pkg::word_t      clo_i,
    input  ex_pkg::word_t      clz_i,
    output ex_pkg::word_t      data_o,
    output ex_pkg::reg_idx_t   reg_addr_o,
    output ex_pkg::word_t      mem_addr_o,
    output ex_pkg::access_op_t mem_access_op_o,
    output ex_pkg::access_sz_t mem_access_sz_o,
    output logic               overflow_o,
    output logic               hilo_we_o,
    output ex_pkg::dword_t     hilo_wdata_o,
    output logic               stall_o,
    output logic               we_cp0_o,
    output ex_pkg::reg_idx_t   cp0_wr_addr_o,
    output ex_pkg::reg_idx_t   cp0_rd_addr_o
);
    import ex_pkg::*;

    logic     is_r;
    logic     is_mdu_op;
    word_t    sign_imm;
    word_t    zero_imm;
    word_t    arith_opnd;
    word_t    logic_opnd;
    word_t    sum;
    word_t    diff;
    logic     add_ovf;
    logic     sub_ovf;
    logic     less;
    reg_idx_t dest;

    assign is_r       = (op_type_i == `OPTYPE_R);
    assign sign_imm   = {{16{immediate_i[15]}}, immediate_i};
    assign zero_imm   = {16'b0, immediate_i};
    assign arith_opnd = is_r ? reg_t_value_i : sign_imm;
    assign logic_opnd = is_r ? reg_t_value_i : zero_imm;
    assign dest       = is_r ? reg_d_i : reg_t_i;

    assign sum  = reg_s_value_i + arith_opnd;
    assign diff = reg_s_value_i - arith_opnd;
    assign add_ovf = !flag_unsigned_i && (reg_s_value_i[31] == arith_opnd[31]) &&
                     (sum[31] != reg_s_value_i[31]);
    assign sub_ovf = !flag_unsigned_i && (reg_s_value_i[31] != arith_opnd[31]) &&
                     (diff[31] != reg_s_value_i[31]);
    assign less = flag_unsigned_i ? (reg_s_value_i < arith_opnd)
                                  : ($signed(reg_s_value_i) < $signed(arith_opnd));

    assign is_mdu_op = (op_i == `OP_MULT) || (op_i == `OP_MADD) || (op_i == `OP_MSUB) ||
                       (op_i == `OP_MUL) || (op_i == `OP_DIV);
    assign stall_o   = is_mdu_op && !mul_done_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back select. Destination 0 means no write.
    always_comb begin
        data_o        = '0;
        reg_addr_o    = '0;
        overflow_o    = 1'b0;
        hilo_we_o     = 1'b0;
        hilo_wdata_o  = '0;
        we_cp0_o      = 1'b0;
        cp0_wr_addr_o = '0;
        cp0_rd_addr_o = '0;
        case (op_i)
            `OP_ADD: begin
                overflow_o = add_ovf;
                if (!add_ovf) begin
                    data_o     = sum;
                    reg_addr_o = dest;
                end
            end
            `OP_SUB: begin
                overflow_o = sub_ovf;
                if (!sub_ovf) begin
                    data_o     = diff;
                    reg_addr_o = dest;
                end
            end
            `OP_AND: begin data_o = reg_s_value_i & logic_opnd; reg_addr_o = dest; end
            `OP_OR:  begin data_o = reg_s_value_i | logic_opnd; reg_addr_o = dest; end
            `OP_XOR: begin data_o = reg_s_value_i ^ logic_opnd; reg_addr_o = dest; end
            `OP_NOR: begin data_o = ~(reg_s_value_i | logic_opnd); reg_addr_o = dest; end
            `OP_SLT: begin data_o = {31'b0, less}; reg_addr_o = dest; end
            `OP_LU:  begin data_o = {immediate_i, 16'b0}; reg_addr_o = reg_t_i; end
            `OP_SLL:  begin data_o = reg_t_value_i << immediate_i[4:0]; reg_addr_o = reg_d_i; end
            `OP_SRL:  begin data_o = reg_t_value_i >> immediate_i[4:0]; reg_addr_o = reg_d_i; end
            `OP_SRA: begin
                data_o     = $signed(reg_t_value_i) >>> immediate_i[4:0];
                reg_addr_o = reg_d_i;
            end
            `OP_SLLV: begin data_o = reg_t_value_i << reg_s_value_i[4:0]; reg_addr_o = reg_d_i; end
            `OP_SRLV: begin data_o = reg_t_value_i >> reg_s_value_i[4:0]; reg_addr_o = reg_d_i; end
            `OP_SRAV: begin
                data_o     = $signed(reg_t_value_i) >>> reg_s_value_i[4:0];
                reg_addr_o = reg_d_i;
            end
            `OP_CLO: begin data_o = clo_i; reg_addr_o = reg_d_i; end
            `OP_CLZ: begin data_o = clz_i; reg_addr_o = reg_d_i; end
            `OP_BGEZAL, `OP_BLTZAL, `OP_JAL: begin
                data_o     = address_i;   // Return address.
                reg_addr_o = 5'd31;
            end
            `OP_JALR: begin data_o = address_i; reg_addr_o = reg_d_i; end
            `OP_LB, `OP_LH, `OP_LL, `OP_LW: reg_addr_o = reg_t_i;
            `OP_SB, `OP_SC, `OP_SH, `OP_SW: begin
                data_o     = reg_t_value_i;
                reg_addr_o = reg_t_i;
            end
            `OP_MOVN: begin
                if (reg_t_value_i != '0) begin
                    data_o     = reg_s_value_i;
                    reg_addr_o = reg_d_i;
                end
            end
            `OP_MOVZ: begin
                if (reg_t_value_i == '0) begin
                    data_o     = reg_s_value_i;
                    reg_addr_o = reg_d_i;
                end
            end
            `OP_MFHI: begin data_o = hilo_value_i[63:32]; reg_addr_o = reg_d_i; end
            `OP_MFLO: begin data_o = hilo_value_i[31:0]; reg_addr_o = reg_d_i; end
            `OP_MTHI: begin
                hilo_we_o    = 1'b1;
                hilo_wdata_o = {reg_s_value_i, hilo_value_i[31:0]};
            end
            `OP_MTLO: begin
                hilo_we_o    = 1'b1;
                hilo_wdata_o = {hilo_value_i[63:32], reg_s_value_i};
            end
            `OP_MFC0: begin
                cp0_rd_addr_o = reg_d_i;
                data_o        = cp0_rd_data_i;
                reg_addr_o    = reg_t_i;
            end
            `OP_MTC0: begin
                we_cp0_o      = 1'b1;
                cp0_wr_addr_o = reg_d_i;
                data_o        = reg_t_value_i;
            end
            `OP_MULT, `OP_MADD, `OP_MSUB, `OP_DIV: begin
                hilo_we_o    = mul_done_i;   // Only in the engine's done cycle.
                hilo_wdata_o = mul_result_i;
            end
            `OP_MUL: begin
                data_o     = mul_result_i[31:0];
                reg_addr_o = mul_done_i ? reg_d_i : 5'd0;
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory request
    always_comb begin
        mem_addr_o      = '0;
        mem_access_op_o = `ACCESS_OP_D2R;
        mem_access_sz_o = `ACCESS_SZ_WORD;
        case (op_i)
            `OP_LB, `OP_LH, `OP_LL, `OP_LW: begin
                mem_addr_o      = reg_s_value_i + sign_imm;
                mem_access_op_o = `ACCESS_OP_M2R;
            end
            `OP_SB, `OP_SH, `OP_SC, `OP_SW: begin
                mem_addr_o      = reg_s_value_i + sign_imm;
                mem_access_op_o = `ACCESS_OP_R2M;
            end
            default: ;
        endcase
        if (op_i == `OP_LB || op_i == `OP_SB) begin
            mem_access_sz_o = `ACCESS_SZ_BYTE;
        end else if (op_i == `OP_LH || op_i == `OP_SH) begin
            mem_access_sz_o = `ACCESS_SZ_HALF;
        end
    end

endmodule

//--- ex_defs.svh
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Operation codes. Zero is left free as the idle code.
`define OP_ADD      8'h01
`define OP_AND      8'h02
`define OP_BGEZAL   8'h03
`define OP_BLTZAL   8'h04
`define OP_JAL      8'h05
`define OP_JALR     8'h06
`define OP_LB       8'h07
`define OP_LH       8'h08
`define OP_LL       8'h09
`define OP_LW       8'h0a
`define OP_LU       8'h0b
`define OP_NOR      8'h0c
`define OP_OR       8'h0d
`define OP_XOR      8'h0e
`define OP_SLT      8'h0f
`define OP_SLL      8'h10
`define OP_SRL      8'h11
`define OP_SB       8'h12
`define OP_SC       8'h13
`define OP_SH       8'h14
`define OP_SW       8'h15
`define OP_SUB      8'h16
`define OP_MFHI     8'h17
`define OP_MFLO     8'h18
`define OP_MTHI     8'h19
`define OP_MTLO     8'h1a
`define OP_MFC0     8'h1b
`define OP_MTC0     8'h1c
`define OP_MULT     8'h1d
`define OP_MSUB     8'h1e
`define OP_MADD     8'h1f
`define OP_DIV      8'h20
`define OP_MUL      8'h21
`define OP_SRA      8'h22
`define OP_SLLV     8'h23
`define OP_SRLV     8'h24
`define OP_SRAV     8'h25
`define OP_CLO      8'h26
`define OP_CLZ      8'h27
`define OP_MOVN     8'h28
`define OP_MOVZ     8'h29

`define OPTYPE_R        2'b00
`define OPTYPE_I        2'b01
`define OPTYPE_J        2'b10

`define ACCESS_OP_D2R   2'b00   // Data to register.
`define ACCESS_OP_M2R   2'b01
`define ACCESS_OP_R2M   2'b10

`define ACCESS_SZ_BYTE  2'b00
`define ACCESS_SZ_HALF  2'b01
`define ACCESS_SZ_WORD  2'b10

`define DIV_STEPS       32      // One quotient bit per cycle.

`endif

//--- ex_pkg.sv
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;      // HI in the upper half.
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [1:0]  op_type_t;
    typedef logic [1:0]  access_op_t;
    typedef logic [1:0]  access_sz_t;

    // Multiply/divide engine.
    typedef enum logic [1:0] {
        MDU_IDLE = 2'd0,
        MDU_BUSY = 2'd1,
        MDU_DONE = 2'd2
    } mdu_state_t;

endpackage

//--- ex_top.sv
`timescale 1ns/100ps

module ex_top (
    input  logic               clk,
    input  logic               rst_i,
    input  ex_pkg::alu_op_t    op_i,
    input  ex_pkg::op_type_t   op_type_i,
    input  ex_pkg::word_t      address_i,
    input  ex_pkg::reg_idx_t   reg_s_i,
    input  ex_pkg::reg_idx_t   reg_t_i,
    input  ex_pkg::reg_idx_t   reg_d_i,
    input  ex_pkg::word_t      reg_s_value_i,
    input  ex_pkg::word_t      reg_t_value_i,
    input  logic [15:0]        immediate_i,
    input  logic               flag_unsigned_i,
    input  ex_pkg::word_t      cp0_rd_data_i,
    output ex_pkg::word_t      data_o,
    output ex_pkg::reg_idx_t   reg_addr_o,
    output ex_pkg::word_t      mem_addr_o,
    output ex_pkg::access_op_t mem_access_op_o,
    output ex_pkg::access_sz_t mem_access_sz_o,
    output logic               overflow_o,
    output logic               stall_o,
    output logic               we_cp0_o,
    output ex_pkg::reg_idx_t   cp0_wr_addr_o,
    output ex_pkg::reg_idx_t   cp0_rd_addr_o
);
    import ex_pkg::*;

    dword_t mul_result;
    logic   mul_done;
    word_t  clo_cnt;
    word_t  clz_cnt;
    logic   hilo_we;
    dword_t hilo_wdata;
    dword_t hilo_value;

    ex u_ex (
        .op_i            (op_i),
        .op_type_i       (op_type_i),
        .address_i       (address_i),
        .reg_s_i         (reg_s_i),
        .reg_t_i         (reg_t_i),
        .reg_d_i         (reg_d_i),
        .reg_s_value_i   (reg_s_value_i),
        .reg_t_value_i   (reg_t_value_i),
        .immediate_i     (immediate_i),
        .flag_unsigned_i (flag_unsigned_i),
        .hilo_value_i    (hilo_value),
        .cp0_rd_data_i   (cp0_rd_data_i),
        .mul_result_i    (mul_result),
        .mul_done_i      (mul_done),
        .clo_i           (clo_cnt),
        .clz_i           (clz_cnt),
        .data_o          (data_o),
        .reg_addr_o      (reg_addr_o),
        .mem_addr_o      (mem_addr_o),
        .mem_access_op_o (mem_access_op_o),
        .mem_access_sz_o (mem_access_sz_o),
        .overflow_o      (overflow_o),
        .hilo_we_o       (hilo_we),
        .hilo_wdata_o    (hilo_wdata),
        .stall_o         (stall_o),
        .we_cp0_o        (we_cp0_o),
        .cp0_wr_addr_o   (cp0_wr_addr_o),
        .cp0_rd_addr_o   (cp0_rd_addr_o)
    );

    multi_cycle u_mdu (
        .clk             (clk),
        .rst_i           (rst_i),
        .op_i            (op_i),
        .flag_unsigned_i (flag_unsigned_i),
        .operand1_i      (reg_s_value_i),
        .operand2_i      (reg_t_value_i),
        .hilo_i          (hilo_value),
        .result_o        (mul_result),
        .done_o          (mul_done)
    );

    count_bit_word u_clo (.data_i(reg_s_value_i), .bit_i(1'b1), .cnt_o(clo_cnt));
    count_bit_word u_clz (.data_i(reg_s_value_i), .bit_i(1'b0), .cnt_o(clz_cnt));

    hilo_reg u_hilo (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (hilo_we),
        .wdata_i (hilo_wdata),
        .hilo_o  (hilo_value)
    );

endmodule

//--- ex_trace.txt
// op type addr rs rt rd rs_val rt_val imm unsigned cp0_rd_data, then expected: data reg_addr
// mem_addr mem_op mem_sz overflow we_cp0 cp0_wr_addr cp0_rd_addr. A lone ff ends the trace.
17 0 0 0 0 3 0 0 0 0 0  0 3 0 0 2 0 0 0 0
01 0 0 1 2 3 5 7 0 0 0  c 3 0 0 2 0 0 0 0
01 1 0 1 4 9 10 0 fffe 0 0  e 4 0 0 2 0 0 0 0
01 0 0 1 2 3 7fffffff 1 0 0 0  0 0 0 0 2 1 0 0 0
01 0 0 1 2 3 7fffffff 1 0 1 0  80000000 3 0 0 2 0 0 0 0
16 0 0 1 2 3 10 3 0 0 0  d 3 0 0 2 0 0 0 0
16 0 0 1 2 3 80000000 1 0 0 0  0 0 0 0 2 1 0 0 0
16 0 0 1 2 3 80000000 1 0 1 0  7fffffff 3 0 0 2 0 0 0 0
02 0 0 1 2 3 f0f0f0f0 ff00ff00 0 0 0  f000f000 3 0 0 2 0 0 0 0
02 1 0 1 4 3 ffffffff 0 8001 0 0  8001 4 0 0 2 0 0 0 0
0d 0 0 1 2 3 12340000 5678 0 0 0  12345678 3 0 0 2 0 0 0 0
0d 1 0 1 4 3 80000000 0 ffff 0 0  8000ffff 4 0 0 2 0 0 0 0
0e 0 0 1 2 3 aaaaaaaa ffff0000 0 0 0  5555aaaa 3 0 0 2 0 0 0 0
0c 0 0 1 2 3 0f0f0000 0f0f 0 0 0  f0f0f0f0 3 0 0 2 0 0 0 0
0f 0 0 1 2 3 ffffffff 1 0 0 0  1 3 0 0 2 0 0 0 0
0f 0 0 1 2 3 ffffffff 1 0 1 0  0 3 0 0 2 0 0 0 0
0f 1 0 1 4 3 fffffff0 0 fff8 0 0  1 4 0 0 2 0 0 0 0
10 0 0 0 2 3 0 3 4 0 0  30 3 0 0 2 0 0 0 0
11 0 0 0 2 3 0 80000000 4 0 0  8000000 3 0 0 2 0 0 0 0
22 0 0 0 2 3 0 80000000 4 0 0  f8000000 3 0 0 2 0 0 0 0
23 0 0 1 2 3 8 ff 0 0 0  ff00 3 0 0 2 0 0 0 0
24 0 0 1 2 3 10 ffff0000 0 0 0  ffff 3 0 0 2 0 0 0 0
25 0 0 1 2 3 104 87654321 0 0 0  f8765432 3 0 0 2 0 0 0 0
0b 1 0 0 4 0 0 0 1234 0 0  12340000 4 0 0 2 0 0 0 0
26 0 0 1 0 3 fff00000 0 0 0 0  c 3 0 0 2 0 0 0 0
26 0 0 1 0 3 ffffffff 0 0 0 0  20 3 0 0 2 0 0 0 0
27 0 0 1 0 3 10000 0 0 0 0  f 3 0 0 2 0 0 0 0
27 0 0 1 0 3 0 0 0 0 0  20 3 0 0 2 0 0 0 0
28 0 0 1 2 3 11111111 1 0 0 0  11111111 3 0 0 2 0 0 0 0
28 0 0 1 2 3 11111111 0 0 0 0  0 0 0 0 2 0 0 0 0
29 0 0 1 2 3 11111111 0 0 0 0  11111111 3 0 0 2 0 0 0 0
29 0 0 1 2 3 11111111 5 0 0 0  0 0 0 0 2 0 0 0 0
07 1 0 1 4 0 1000 0 10 0 0  0 4 1010 1 0 0 0 0 0
08 1 0 1 4 0 1000 0 fffe 0 0  0 4 ffe 1 1 0 0 0 0
0a 1 0 1 4 0 1000 0 4 0 0  0 4 1004 1 2 0 0 0 0
12 1 0 1 4 0 1000 deadbeef 1 0 0  deadbeef 4 1001 2 0 0 0 0 0
14 1 0 1 4 0 1000 deadbeef fff0 0 0  deadbeef 4 ff0 2 1 0 0 0 0
15 1 0 1 4 0 1000 deadbeef 8 0 0  deadbeef 4 1008 2 2 0 0 0 0
05 2 400008 0 0 0 0 0 0 0 0  400008 1f 0 0 2 0 0 0 0
03 1 400010 1 0 0 0 0 0 0 0  400010 1f 0 0 2 0 0 0 0
06 0 400020 1 0 3 0 0 0 0 0  400020 3 0 0 2 0 0 0 0
1b 0 0 0 4 c 0 0 0 0 ff01  ff01 4 0 0 2 0 0 0 c
1c 0 0 0 4 e 0 12345678 0 0 0  12345678 0 0 0 2 0 1 e 0
1d 0 0 1 2 0 fffffffe 3 0 0 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  ffffffff 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffffa 3 0 0 2 0 0 0 0
1d 0 0 1 2 0 fffffffe 3 0 1 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  2 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffffa 3 0 0 2 0 0 0 0
1f 0 0 1 2 0 10 fffffff0 0 0 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  2 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffefa 3 0 0 2 0 0 0 0
1f 0 0 1 2 0 10000 10000 0 1 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  3 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffefa 3 0 0 2 0 0 0 0
1e 0 0 1 2 0 ffffffff 5 0 0 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  3 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffeff 3 0 0 2 0 0 0 0
1e 0 0 1 2 0 2 80000000 0 1 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  2 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffeff 3 0 0 2 0 0 0 0
20 0 0 1 2 0 fffffff9 2 0 0 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  ffffffff 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  fffffffd 3 0 0 2 0 0 0 0
20 0 0 1 2 0 fffffff9 2 0 1 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  1 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  7ffffffc 3 0 0 2 0 0 0 0
21 0 0 1 2 3 10001 10001 0 0 0  20001 3 0 0 2 0 0 0 0
19 0 0 1 0 0 a5a5a5a5 0 0 0 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  a5a5a5a5 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  7ffffffc 3 0 0 2 0 0 0 0
1a 0 0 1 0 0 5a5a5a5a 0 0 0 0  0 0 0 0 2 0 0 0 0
17 0 0 0 0 3 0 0 0 0 0  a5a5a5a5 3 0 0 2 0 0 0 0
18 0 0 0 0 3 0 0 0 0 0  5a5a5a5a 3 0 0 2 0 0 0 0
ff

//--- hilo_reg.sv
`timescale 1ns/100ps

module hilo_reg (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           we_i,
    input  ex_pkg::dword_t wdata_i,
    output ex_pkg::dword_t hilo_o
);

    // HI in [63:32], LO in [31:0].
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_o <= '0;
        end else if (we_i) begin
            hilo_o <= wdata_i;
        end
    end

endmodule

//--- multi_cycle.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module multi_cycle (
    input  logic            clk,
    input  logic            rst_i,
    input  ex_pkg::alu_op_t op_i,
    input  logic            flag_unsigned_i,
    input  ex_pkg::word_t   operand1_i,
    input  ex_pkg::word_t   operand2_i,
    input  ex_pkg::dword_t  hilo_i,
    output ex_pkg::dword_t  result_o,
    output logic            done_o
);
    import ex_pkg::*;

    localparam int STEP_W = $clog2(`DIV_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DIV_STEPS - 1);

    mdu_state_t        state_q;
    logic [STEP_W-1:0] step_q;
    alu_op_t           op_q;
    logic              unsigned_q;
    logic              neg_quo_q;
    logic              neg_rem_q;
    word_t             opa_q;     // Dividend, then quotient, when dividing.
    word_t             opb_q;
    word_t             rem_q;
    dword_t            result_q;

    logic        start;
    logic        is_div;
    logic        last;
    logic        a_neg;
    logic        b_neg;
    dword_t      ext_a;
    dword_t      ext_b;
    dword_t      product;
    logic [32:0] div_shift;
    logic        div_fit;
    word_t       div_diff;
    word_t       rem_next;
    word_t       quo_next;

    assign start = (op_i == `OP_MULT) || (op_i == `OP_MADD) || (op_i == `OP_MSUB) ||
                   (op_i == `OP_MUL) || (op_i == `OP_DIV);
    assign is_div = (op_i == `OP_DIV);
    assign a_neg  = !flag_unsigned_i && operand1_i[31];
    assign b_neg  = !flag_unsigned_i && operand2_i[31];
    assign last   = (op_q != `OP_DIV) || (step_q == LAST_STEP);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    assign ext_a   = unsigned_q ? {32'b0, opa_q} : {{32{opa_q[31]}}, opa_q};
    assign ext_b   = unsigned_q ? {32'b0, opb_q} : {{32{opb_q[31]}}, opb_q};
    assign product = ext_a * ext_b;

    // One restoring step on magnitudes.
    assign div_shift = {rem_q, opa_q[31]};
    assign div_fit   = div_shift >= {1'b0, opb_q};
    assign div_diff  = div_shift[31:0] - opb_q;
    assign rem_next  = div_fit ? div_diff : div_shift[31:0];
    assign quo_next  = {opa_q[30:0], div_fit};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= MDU_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                MDU_IDLE: begin
                    if (start) begin
                        state_q <= MDU_BUSY;
                        step_q  <= '0;
                    end
                end
                MDU_BUSY: begin
                    if (last) begin
                        state_q <= MDU_DONE;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: state_q <= MDU_IDLE;   // Done lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MDU_IDLE && start) begin
            op_q       <= op_i;
            unsigned_q <= flag_unsigned_i;
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;   // Remainder follows the dividend.
            opa_q      <= (is_div && a_neg) ? -operand1_i : operand1_i;
            opb_q      <= (is_div && b_neg) ? -operand2_i : operand2_i;
            rem_q      <= '0;
        end else if (state_q == MDU_BUSY) begin
            if (!last) begin
                rem_q <= rem_next;
                opa_q <= quo_next;
            end else begin
                case (op_q)
                    `OP_MADD: result_q <= hilo_i + product;
                    `OP_MSUB: result_q <= hilo_i - product;
                    `OP_DIV:  result_q <= {neg_rem_q ? -rem_next : rem_next,
                                           neg_quo_q ? -quo_next : quo_next};
                    default:  result_q <= product;
                endcase
            end
        end
    end

    assign result_o = result_q;
    assign done_o   = (state_q == MDU_DONE);

endmodule

//--- sim.f
+incdir+.
ex_pkg.sv
count_bit_word.sv
multi_cycle.sv
hilo_reg.sv
ex.sv
ex_top.sv
tb_ex_top.sv

//--- tb_ex_top.sv
`timescale 1ns/100ps
`include "ex_defs.svh"

module tb_ex_top;
    import ex_pkg::*;

    localparam int    FIELDS   = 20;    // Words per trace record.
    localparam int    EXP      = 11;    // First expected-value word of a record.
    localparam int    MAX_REC  = 128;
    localparam int    WAIT_MAX = `DIV_STEPS + 10;
    localparam word_t END_OP   = 32'h0000_00ff;

    logic        clk = 1'b0;
    logic        rst_i;
    alu_op_t     op_i;
    op_type_t    op_type_i;
    word_t       address_i;
    reg_idx_t    reg_s_i;
    reg_idx_t    reg_t_i;
    reg_idx_t    reg_d_i;
    word_t       reg_s_value_i;
    word_t       reg_t_value_i;
    logic [15:0] immediate_i;
    logic        flag_unsigned_i;
    word_t       cp0_rd_data_i;
    word_t       data_o;
    reg_idx_t    reg_addr_o;
    word_t       mem_addr_o;
    access_op_t  mem_access_op_o;
    access_sz_t  mem_access_sz_o;
    logic        overflow_o;
    logic        stall_o;
    logic        we_cp0_o;
    reg_idx_t    cp0_wr_addr_o;
    reg_idx_t    cp0_rd_addr_o;

    word_t trace_mem [0:FIELDS*MAX_REC-1];

    always #50 clk = ~clk;

    ex_top UUT (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        $display("** Error: %s expected %h, got %h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic drive_inputs(input int base);
        op_i            <= trace_mem[base][7:0];
        op_type_i       <= trace_mem[base+1][1:0];
        address_i       <= trace_mem[base+2];
        reg_s_i         <= trace_mem[base+3][4:0];
        reg_t_i         <= trace_mem[base+4][4:0];
        reg_d_i         <= trace_mem[base+5][4:0];
        reg_s_value_i   <= trace_mem[base+6];
        reg_t_value_i   <= trace_mem[base+7];
        immediate_i     <= trace_mem[base+8][15:0];
        flag_unsigned_i <= trace_mem[base+9][0];
        cp0_rd_data_i   <= trace_mem[base+10];
    endtask

    // Capture edge and busy cycles of the engine, before its done cycle.
    function automatic int stall_cycles(input alu_op_t op);
        if (op == `OP_DIV) begin
            return `DIV_STEPS + 1;
        end else if (op == `OP_MULT || op == `OP_MADD || op == `OP_MSUB ||
                     op == `OP_MUL) begin
            return 2;
        end
        return 0;
    endfunction

    // Outputs are sampled on the falling edge, away from the drive edge.
    task automatic wait_stall_clear(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (stall_o && cycles < WAIT_MAX) begin
            cycles++;
            @(negedge clk);
        end
        if (stall_o) begin
            $display("Testbench failed");
            $fatal(1, "stall_o did not clear within %0d cycles", WAIT_MAX);
        end
    endtask

    task automatic check_outputs(input int base, input int stalled);
        assert (stalled == stall_cycles(trace_mem[base][7:0]))
            else report_mismatch("stall_o cycles", stall_cycles(trace_mem[base][7:0]),
                                 stalled);
        assert (data_o == trace_mem[base+EXP])
            else report_mismatch("data_o", trace_mem[base+EXP], data_o);
        assert (32'(reg_addr_o) == trace_mem[base+EXP+1])
            else report_mismatch("reg_addr_o", trace_mem[base+EXP+1], 32'(reg_addr_o));
        assert (mem_addr_o == trace_mem[base+EXP+2])
            else report_mismatch("mem_addr_o", trace_mem[base+EXP+2], mem_addr_o);
        assert (32'(mem_access_op_o) == trace_mem[base+EXP+3])
            else report_mismatch("mem_access_op_o", trace_mem[base+EXP+3],
                                 32'(mem_access_op_o));
        assert (32'(mem_access_sz_o) == trace_mem[base+EXP+4])
            else report_mismatch("mem_access_sz_o", trace_mem[base+EXP+4],
                                 32'(mem_access_sz_o));
        assert (32'(overflow_o) == trace_mem[base+EXP+5])
            else report_mismatch("overflow_o", trace_mem[base+EXP+5], 32'(overflow_o));
        assert (32'(we_cp0_o) == trace_mem[base+EXP+6])
            else report_mismatch("we_cp0_o", trace_mem[base+EXP+6], 32'(we_cp0_o));
        assert (32'(cp0_wr_addr_o) == trace_mem[base+EXP+7])
            else report_mismatch("cp0_wr_addr_o", trace_mem[base+EXP+7], 32'(cp0_wr_addr_o));
        assert (32'(cp0_rd_addr_o) == trace_mem[base+EXP+8])
            else report_mismatch("cp0_rd_addr_o", trace_mem[base+EXP+8], 32'(cp0_rd_addr_o));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    initial begin
        int rec;
        int base;
        int stalled;
        rst_i           = 1'b1;
        op_i            = '0;
        op_type_i       = '0;
        address_i       = '0;
        reg_s_i         = '0;
        reg_t_i         = '0;
        reg_d_i         = '0;
        reg_s_value_i   = '0;
        reg_t_value_i   = '0;
        immediate_i     = '0;
        flag_unsigned_i = 1'b0;
        cp0_rd_data_i   = '0;
        $readmemh("ex_trace.txt", trace_mem);

        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        rec = 0;
        while (rec < MAX_REC && trace_mem[rec*FIELDS] != END_OP) begin
            base = rec * FIELDS;
            @(posedge clk);
            drive_inputs(base);   // The next edge after stall clears consumes it.
            wait_stall_clear(stalled);
            check_outputs(base, stalled);
            rec++;
        end

        if (rec == 0 || rec == MAX_REC) begin
            $display("Testbench failed");
            $fatal(1, "trace file is empty or has no end record");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
